// ==== rtl/ntm_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_apb_regs
  import ntm_vector_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-1:0] paddr,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  output lane_in_t          lane0_in,
  output lane_in_t          lane1_in,
  input  lane_out_t         lane0_out,
  input  lane_out_t         lane1_out,
  output job_t              job,
  input  logic              comb_done,
  input  logic [data_w-1:0] result
);

  // Registers and job state
  logic [data_w-1:0] modulo_q;
  logic [data_w-1:0] size_q;
  logic [data_w-1:0] count_q;
  logic              busy_q;
  logic              done_q;
  logic              comb_wait_q;

  // Address decode
  logic access;
  logic wr;
  logic sel_ctrl;
  logic sel_modulo;
  logic sel_size;
  logic sel_data;
  logic sel_status;
  logic sel_result;
  logic mapped;

  // Element steering and checks
  logic lane_sel;
  logic target_busy;
  logic first_slot;
  logic mod_err;
  logic data_err;
  logic err;
  logic stall;
  logic push;
  logic start;
  logic combine;

  //////////////////////////////
  // Decode and error rules
  //////////////////////////////

  assign access     = psel & penable;
  assign wr         = access & pwrite;
  assign sel_ctrl   = (paddr == reg_ctrl);
  assign sel_modulo = (paddr == reg_modulo);
  assign sel_size   = (paddr == reg_size);
  assign sel_data   = (paddr == reg_data);
  assign sel_status = (paddr == reg_status);
  assign sel_result = (paddr == reg_result);
  assign mapped     = sel_ctrl | sel_modulo | sel_size | sel_data | sel_status | sel_result;

  // Low count bit picks the lane, even to lane 0
  assign lane_sel    = count_q[0];
  assign target_busy = lane_sel ? lane1_out.busy : lane0_out.busy;
  // Element 0 or 1 opens its lane
  assign first_slot  = (count_q[data_w-1:1] == '0);

  assign mod_err  = (pwdata < min_modulo);
  // No job, job already full, or element not reduced
  assign data_err = ~busy_q | (count_q >= size_q) | (pwdata >= modulo_q);
  assign err      = ~mapped | (pwrite & sel_modulo & mod_err) | (pwrite & sel_data & data_err);

  // Wait states while the target lane multiplies
  assign stall   = wr & sel_data & ~data_err & target_busy;
  assign pready  = ~stall;
  assign pslverr = access & pready & err;

  assign push  = wr & sel_data & ~data_err & ~target_busy;
  // Start ignored while a job runs
  assign start = wr & sel_ctrl & pwdata[0] & ~busy_q;

  // All elements in, both lanes idle
  assign combine = busy_q & ~comb_wait_q & (count_q == size_q) &
                   ~lane0_out.busy & ~lane1_out.busy;

  //////////////////////////////
  // Lane and combiner drive
  //////////////////////////////

  always_comb begin
    // First alone at start presets the partial
    lane0_in.valid   = push & ~lane_sel;
    lane0_in.first   = start | (push & ~lane_sel & first_slot);
    lane0_in.element = pwdata;
    lane0_in.modulo  = modulo_q;

    lane1_in.valid   = push & lane_sel;
    lane1_in.first   = start | (push & lane_sel & first_slot);
    lane1_in.element = pwdata;
    lane1_in.modulo  = modulo_q;

    job.combine = combine;
    job.modulo  = modulo_q;
  end

  //////////////////////////////
  // Register and job state
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      modulo_q    <= min_modulo;
      size_q      <= '0;
      count_q     <= '0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      comb_wait_q <= 1'b0;
    end else begin
      // Illegal modulus leaves the old one
      if (wr & sel_modulo & ~mod_err) begin
        modulo_q <= pwdata;
      end
      if (wr & sel_size) begin
        size_q <= pwdata;
      end
      if (start) begin
        busy_q  <= 1'b1;
        done_q  <= 1'b0;
        count_q <= '0;
      end else if (push) begin
        count_q <= count_q + 1'b1;
      end
      // One combine per job
      if (combine) begin
        comb_wait_q <= 1'b1;
      end
      if (comb_done) begin
        busy_q      <= 1'b0;
        done_q      <= 1'b1;
        comb_wait_q <= 1'b0;
      end
    end
  end

  // Read mux, ctrl and data read as 0
  always_comb begin
    case (paddr)
      reg_modulo: prdata = modulo_q;
      reg_size:   prdata = size_q;
      reg_status: prdata = {{(data_w-2){1'b0}}, done_q, busy_q};
      reg_result: prdata = result;
      default:    prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/ntm_lane_combiner.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_lane_combiner
  import ntm_vector_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  job_t              job,
  input  lane_out_t         lane0,
  input  lane_out_t         lane1,
  output logic              done,
  output logic [data_w-1:0] result
);

  // Multiplier hookup
  logic              mul_done;
  logic [data_w-1:0] mul_product;

  // Last finished job
  logic [data_w-1:0] result_q;

  //////////////////////////////
  // Final product
  //////////////////////////////

  // Even partial times odd partial, job modulus
  // Both partials already below the modulus
  ntm_modular_multiplier u_mul (
    .CLK     (CLK),
    .RST     (RST),
    .start   (job.combine),
    .a       (lane0.partial),
    .b       (lane1.partial),
    .m       (job.modulo),
    .done    (mul_done),
    .product (mul_product)
  );

  // Hold until the next job completes
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result_q <= '0;
    end else if (mul_done) begin
      result_q <= mul_product;
    end
  end

  // Done straight from the multiplier
  assign done = mul_done;

  // New value already visible in the done cycle
  assign result = mul_done ? mul_product : result_q;

endmodule

`default_nettype wire

// ==== rtl/ntm_modular_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_modular_multiplier
  import ntm_vector_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  input  logic [data_w-1:0] m,
  output logic              done,
  output logic [data_w-1:0] product
);

  // Control
  logic             run_q;
  logic [cnt_w-1:0] cnt_q;

  // Operands latched at start
  logic [data_w-1:0] a_q;
  logic [data_w-1:0] b_q;
  logic [data_w-1:0] m_q;

  // Running remainder, always below m
  logic [data_w-1:0] r_q;

  // One step of the loop
  logic [data_w:0]   dbl;
  logic [data_w:0]   dbl_sub;
  logic [data_w-1:0] dbl_red;
  logic [data_w:0]   sum;
  logic [data_w:0]   sum_sub;
  logic [data_w-1:0] sum_red;
  logic [data_w-1:0] r_next;

  //////////////////////////////
  // Step datapath
  //////////////////////////////

  always_comb begin
    // Double, one spare bit for the carry
    dbl     = {r_q, 1'b0};
    dbl_sub = dbl - {1'b0, m_q};
    dbl_red = (dbl >= {1'b0, m_q}) ? dbl_sub[data_w-1:0] : dbl[data_w-1:0];
    // Conditional add of a, same single reduction
    sum     = {1'b0, dbl_red} + {1'b0, a_q};
    sum_sub = sum - {1'b0, m_q};
    sum_red = (sum >= {1'b0, m_q}) ? sum_sub[data_w-1:0] : sum[data_w-1:0];
    // MSB of b selects
    r_next  = b_q[data_w-1] ? sum_red : dbl_red;
  end

  //////////////////////////////
  // Step sequencing
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      run_q <= 1'b0;
      cnt_q <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        run_q <= 1'b1;
        cnt_q <= '0;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        // Last bit of b this cycle
        if (cnt_q == cnt_w'(mul_cycles - 1)) begin
          run_q <= 1'b0;
          done  <= 1'b1;
        end
      end
    end
  end

  // Operand and remainder registers
  always_ff @(posedge CLK) begin
    if (start) begin
      a_q <= a;
      b_q <= b;
      m_q <= m;
      r_q <= '0;
    end else if (run_q) begin
      r_q <= r_next;
      b_q <= {b_q[data_w-2:0], 1'b0};
    end
  end

  // Valid while done is high
  assign product = r_q;

endmodule

`default_nettype wire

// ==== rtl/ntm_product_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_product_lane
  import ntm_vector_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  lane_in_t  lane_in,
  output lane_out_t lane_out
);

  // Lane state
  logic              busy_q;
  logic [data_w-1:0] partial_q;

  // Multiplier hookup
  logic [data_w-1:0] mul_a;
  logic              mul_done;
  logic [data_w-1:0] mul_product;

  //////////////////////////////
  // Multiplicand select
  //////////////////////////////

  // First element of the job starts from 1
  assign mul_a = lane_in.first ? {{(data_w-1){1'b0}}, 1'b1} : partial_q;

  // Partial times element modulo m
  ntm_modular_multiplier u_mul (
    .CLK     (CLK),
    .RST     (RST),
    .start   (lane_in.valid),
    .a       (mul_a),
    .b       (lane_in.element),
    .m       (lane_in.modulo),
    .done    (mul_done),
    .product (mul_product)
  );

  //////////////////////////////
  // Busy and partial
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q    <= 1'b0;
      partial_q <= {{(data_w-1){1'b0}}, 1'b1};
    end else begin
      if (lane_in.valid) begin
        // Held until the multiplier finishes
        busy_q <= 1'b1;
      end else if (mul_done) begin
        busy_q    <= 1'b0;
        partial_q <= mul_product;
      end else if (lane_in.first) begin
        // Job start preset, no element attached
        // Covers a lane that never gets an element
        partial_q <= {{(data_w-1){1'b0}}, 1'b1};
      end
    end
  end

  // Status and partial back out
  always_comb begin
    lane_out.busy    = busy_q;
    lane_out.partial = partial_q;
  end

endmodule

`default_nettype wire

// ==== rtl/ntm_vector_pkg.sv ====
`default_nettype none

package ntm_vector_pkg;

  //////////////////////////////
  // Widths and timing
  //////////////////////////////

  // Operand, modulus and result width
  localparam int data_w = 16;

  // APB address width
  localparam int addr_w = 8;

  // One operand bit per cycle
  localparam int mul_cycles = data_w;

  // Step counter of the multiplier
  localparam int cnt_w = $clog2(mul_cycles + 1);

  // Smallest legal modulus, also its reset value
  localparam logic [data_w-1:0] min_modulo = 16'd2;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Bit 0 starts a job
  localparam logic [addr_w-1:0] reg_ctrl   = 8'h00;
  localparam logic [addr_w-1:0] reg_modulo = 8'h04;
  // Number of elements in the job
  localparam logic [addr_w-1:0] reg_size   = 8'h08;
  // Element push, write only
  localparam logic [addr_w-1:0] reg_data   = 8'h0C;
  // Bit 0 busy, bit 1 done
  localparam logic [addr_w-1:0] reg_status = 8'h10;
  localparam logic [addr_w-1:0] reg_result = 8'h14;

  //////////////////////////////
  // Block interfaces
  //////////////////////////////

  // Register block to one lane
  typedef struct packed {
    logic              valid;
    logic              first;
    logic [data_w-1:0] element;
    logic [data_w-1:0] modulo;
  } lane_in_t;

  // Lane back to register block and combiner
  typedef struct packed {
    logic              busy;
    logic [data_w-1:0] partial;
  } lane_out_t;

  // Register block to combiner
  typedef struct packed {
    logic              combine;
    logic [data_w-1:0] modulo;
  } job_t;

endpackage

`default_nettype wire

// ==== rtl/ntm_vector_product_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_product_top
  import ntm_vector_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-1:0] paddr,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  // Lane links
  lane_in_t  lane0_in;
  lane_in_t  lane1_in;
  lane_out_t lane0_out;
  lane_out_t lane1_out;

  // Combiner links
  job_t              job;
  logic              comb_done;
  logic [data_w-1:0] result;

  // APB register block and job control
  ntm_apb_regs u_regs (
    .CLK       (CLK),
    .RST       (RST),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .lane0_in  (lane0_in),
    .lane1_in  (lane1_in),
    .lane0_out (lane0_out),
    .lane1_out (lane1_out),
    .job       (job),
    .comb_done (comb_done),
    .result    (result)
  );

  // Even elements
  ntm_product_lane u_lane0 (
    .CLK      (CLK),
    .RST      (RST),
    .lane_in  (lane0_in),
    .lane_out (lane0_out)
  );

  // Odd elements
  ntm_product_lane u_lane1 (
    .CLK      (CLK),
    .RST      (RST),
    .lane_in  (lane1_in),
    .lane_out (lane1_out)
  );

  // Partial times partial
  ntm_lane_combiner u_comb (
    .CLK    (CLK),
    .RST    (RST),
    .job    (job),
    .lane0  (lane0_out),
    .lane1  (lane1_out),
    .done   (comb_done),
    .result (result)
  );

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/ntm_vector_pkg.sv
rtl/ntm_modular_multiplier.sv
rtl/ntm_product_lane.sv
rtl/ntm_lane_combiner.sv
rtl/ntm_apb_regs.sv
rtl/ntm_vector_product_top.sv
verif/ntm_vector_product_checker.sv
verif/ntm_vector_product_tb.sv

// ==== verif/ntm_vector_product_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_product_checker
  import ntm_vector_pkg::*;
(
  input logic              CLK,
  input logic              RST,
  input logic              psel,
  input logic              penable,
  input logic              pready,
  input logic              pslverr,
  input logic [data_w-1:0] prdata,
  input logic              busy,
  input logic              done,
  input logic              start,
  input logic [data_w-1:0] result
);

  // Failure tally for the end of run summary
  int unsigned fail_cnt = 0;

  //////////////////////////////
  // APB protocol
  //////////////////////////////

  // Error response only in a completing access cycle
  a_slverr_phase: assert property (@(posedge CLK) disable iff (RST)
    pslverr |-> (pready && psel && penable))
  else begin
    $error("pslverr outside a completing access phase");
    fail_cnt++;
  end

  // Handshake and read data always known
  a_no_x: assert property (@(posedge CLK) disable iff (RST)
    !$isunknown(pready) && !$isunknown(prdata))
  else begin
    $error("pready or prdata unknown after reset");
    fail_cnt++;
  end

  //////////////////////////////
  // Job status
  //////////////////////////////

  a_busy_done: assert property (@(posedge CLK) disable iff (RST)
    !(busy && done))
  else begin
    $error("busy and done high together");
    fail_cnt++;
  end

  // Finished result holds until the next start
  a_result_hold: assert property (@(posedge CLK) disable iff (RST)
    (done && !start) |=> $stable(result))
  else begin
    $error("result changed while done was set");
    fail_cnt++;
  end

endmodule

bind ntm_apb_regs ntm_vector_product_checker u_checker (
  .CLK     (CLK),
  .RST     (RST),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .prdata  (prdata),
  .busy    (busy_q),
  .done    (done_q),
  .start   (start),
  .result  (result)
);

`default_nettype wire

// ==== verif/ntm_vector_product_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_product_tb
  import ntm_vector_pkg::*;
();

  localparam int clk_period = 10;
  localparam int num_random = 16;
  localparam int max_elems  = 10;
  // Random jobs plus the directed ones
  localparam int num_jobs   = num_random + 8;
  // Every element may wait out a full lane multiply with 4x margin
  localparam int watchdog_cycles = num_jobs * max_elems * (mul_cycles + 4) * 4;

  logic              CLK = 1'b0;
  logic              RST;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [addr_w-1:0] paddr;
  logic [data_w-1:0] pwdata;
  logic [data_w-1:0] prdata;
  logic              pready;
  logic              pslverr;

  // Scoreboard
  int test_errors;
  int tests_ok;
  int tests_bad;
  int total_waits;

  // Current job for the reference model
  logic [data_w-1:0] job_elems[$];
  int unsigned       job_modulo;

  ntm_vector_product_top u_dut (
    .CLK     (CLK),
    .RST     (RST),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #(clk_period / 2) CLK = ~CLK;

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////

  // Plain integer product reduced after each step
  function automatic logic [data_w-1:0] model_product();
    longint unsigned acc;
    acc = 1 % job_modulo;
    foreach (job_elems[i]) begin
      acc = (acc * job_elems[i]) % job_modulo;
    end
    return acc[data_w-1:0];
  endfunction

  task automatic check_value(input string name, input logic [data_w-1:0] exp,
                             input logic [data_w-1:0] got);
    assert (got === exp)
    else begin
      $display("** Error: %s expected 0x%h, got 0x%h at %0d ns", name, exp, got, $time);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      tests_ok++;
      $display("[%0d ns] test %s ok", $time, name);
    end else begin
      tests_bad++;
      $display("[%0d ns] test %s FAIL with %0d errors", $time, name, test_errors);
    end
    test_errors = 0;
  endtask

  //////////////////////////////
  // APB master
  //////////////////////////////

  // Entered and left 1 ns after a rising edge
  task automatic apb_xfer(input logic wr, input logic [addr_w-1:0] addr,
                          input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata,
                          output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    // Sample mid cycle away from the edge
    @(negedge CLK);
    // Only element pushes may hold off the transfer
    if (!(wr && addr == reg_data)) begin
      check_value("pready", 1, pready);
    end
    while (!pready) begin
      total_waits++;
      @(negedge CLK);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge CLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                           output logic err);
    logic [data_w-1:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
                          output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  // Accesses that must complete without error
  task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    logic err;
    apb_write(addr, data, err);
    check_value("pslverr", 0, err);
  endtask

  task automatic read_reg(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
    logic err;
    apb_read(addr, data, err);
    check_value("pslverr", 0, err);
  endtask

  //////////////////////////////
  // Job sequencing
  //////////////////////////////

  task automatic start_job(input int unsigned m, input int unsigned n);
    logic [data_w-1:0] status;
    job_modulo = m;
    write_reg(reg_modulo, m);
    write_reg(reg_size, n);
    write_reg(reg_ctrl, 16'h0001);
    // Old done cleared and busy set
    read_reg(reg_status, status);
    check_value("status", 16'h0001, status);
  endtask

  task automatic push_elements();
    foreach (job_elems[i]) begin
      write_reg(reg_data, job_elems[i]);
    end
  endtask

  // Busy has to stay up while polling for done
  task automatic finish_job();
    logic [data_w-1:0] status;
    logic [data_w-1:0] result;
    status = '0;
    while (!status[1]) begin
      read_reg(reg_status, status);
      if (!status[1]) begin
        check_value("status.busy", 1, status[0]);
      end
    end
    check_value("status", 16'h0002, status);
    read_reg(reg_result, result);
    check_value("result", model_product(), result);
  endtask

  task automatic run_job(input int unsigned m);
    start_job(m, job_elems.size());
    push_elements();
    finish_job();
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    logic [data_w-1:0] rdata;
    logic              err;
    int unsigned       m;
    int unsigned       n;
    void'($urandom(72069));
    RST         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    test_errors = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    total_waits = 0;
    job_modulo  = 2;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Reset values then readback
    read_reg(reg_status, rdata);
    check_value("status", 16'h0000, rdata);
    read_reg(reg_modulo, rdata);
    check_value("modulo", 16'h0002, rdata);
    read_reg(reg_size, rdata);
    check_value("size", 16'h0000, rdata);
    write_reg(reg_modulo, 16'hBEEF);
    read_reg(reg_modulo, rdata);
    check_value("modulo", 16'hBEEF, rdata);
    write_reg(reg_size, 16'h0009);
    read_reg(reg_size, rdata);
    check_value("size", 16'h0009, rdata);
    end_test("reset_readback");

    // 5005 mod 97 through both lanes and the combiner
    job_elems = '{16'd5, 16'd7, 16'd11, 16'd13};
    run_job(97);
    end_test("directed");

    // Empty job first then random sizes
    job_elems.delete();
    run_job(1234);
    for (int j = 0; j < num_random; j++) begin
      m = $urandom_range(65535, 2);
      n = $urandom_range(max_elems - 1, 0);
      job_elems.delete();
      repeat (n) job_elems.push_back($urandom_range(m - 1, 0));
      run_job(m);
    end
    end_test("random");

    // Unmapped address
    apb_read(8'h18, rdata, err);
    check_value("pslverr", 1, err);
    check_value("prdata", 16'h0000, rdata);
    apb_write(8'h1C, 16'h1234, err);
    check_value("pslverr", 1, err);
    // Illegal moduli keep the old one
    write_reg(reg_modulo, 101);
    apb_write(reg_modulo, 16'd0, err);
    check_value("pslverr", 1, err);
    apb_write(reg_modulo, 16'd1, err);
    check_value("pslverr", 1, err);
    read_reg(reg_modulo, rdata);
    check_value("modulo", 16'd101, rdata);
    // Element with no job running
    apb_write(reg_data, 16'd3, err);
    check_value("pslverr", 1, err);
    // Element equal to the modulus is dropped
    job_elems = '{16'd4, 16'd9, 16'd100};
    start_job(101, 3);
    apb_write(reg_data, 16'd101, err);
    check_value("pslverr", 1, err);
    push_elements();
    finish_job();
    end_test("error_resp");

    // Back to back pushes into busy lanes
    total_waits = 0;
    job_elems.delete();
    repeat (8) job_elems.push_back($urandom_range(65520, 0));
    run_job(65521);
    assert (total_waits > 0)
    else begin
      $display("Back-pressure test saw no wait states on element writes");
      test_errors++;
    end
    end_test("backpressure");

    // New job must not inherit old partials
    job_elems = '{16'd1000, 16'd999, 16'd3};
    run_job(1009);
    job_elems = '{16'd2};
    run_job(1009);
    job_elems = '{16'd6, 16'd6};
    run_job(7);
    end_test("restart");

    $display("Summary: %0d tests ok, %0d tests failing, %0d checker failures",
             tests_ok, tests_bad, u_dut.u_regs.u_checker.fail_cnt);
    if (tests_bad == 0 && u_dut.u_regs.u_checker.fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: run still going after %0d cycles", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
